// File: bench/exec_unit_props.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit_props import exec_pkg::*; (
   input logic s_clk_i,
   input logic rst_i,
   input logic stall_i,
   input logic issue_i,
   input logic busy_o,
   input wb_t  wb_o
);
   a_reset_quiet: assert property (@(posedge s_clk_i) rst_i |=> !wb_o.valid)
      else $error("wb_o.valid high after reset");

   // issuer must wait out an mdu op
   a_no_issue_busy: assert property (@(posedge s_clk_i) disable iff (rst_i) busy_o |-> !issue_i)
      else $error("issue_i raised while busy_o high");

   a_stall_no_wb: assert property (@(posedge s_clk_i) disable iff (rst_i) stall_i |=> !wb_o.valid)
      else $error("wb_o.valid after a stalled cycle");

endmodule

bind exec_unit exec_unit_props u_props (
   .s_clk_i (s_clk_i),
   .rst_i   (rst_i),
   .stall_i (stall_i),
   .issue_i (issue_i),
   .busy_o  (busy_o),
   .wb_o    (wb_o)
);

`default_nettype wire

// File: bench/exec_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module exec_unit_tb import isa_pkg::*, exec_pkg::*; ;
   localparam int N_ALU     = 200;
   localparam int N_MDU     = 40;
   localparam int LIMIT     = 2 * (N_ALU + N_MDU * 40) + 500; // cycles with a generous margin
   localparam int DRAIN_MAX = 2 * `MDU_STEPS; // longest wait for owed records

   logic                  s_clk_i;
   logic                  rst_i;
   logic                  stall_i;
   logic                  flush_i;
   logic                  issue_i;
   instr_u                instr_i;
   logic [`EXEC_XLEN-1:0] op1_i;
   logic [`EXEC_XLEN-1:0] op2_i;
   logic [`EXEC_XLEN-1:0] pc_i;
   wb_t                   wb_o;
   logic                  busy_o;

   logic [31:0] lfsr_q;
   int          cyc_q = 0;
   wb_t         exp_q[$];  // records still owed in issue order
   int          due_q[$];  // due cycle of each record or -1 if untimed
   logic [2:0]  mdu_f3 [6];

   exec_unit DUT (.*);

   always #20 s_clk_i = ~s_clk_i; // 40 ns period

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic fail_value(input string name, input logic [31:0] e, input logic [31:0] g);
      abort_run($sformatf("FAIL %s expected %h got %h", name, e, g));
   endtask

   task automatic check_wb(input wb_t exp, input wb_t got);
      if (got.illegal !== exp.illegal)
         fail_value("wb_o.illegal", 32'(exp.illegal), 32'(got.illegal));
      if (got.rd !== exp.rd)           fail_value("wb_o.rd", 32'(exp.rd), 32'(got.rd));
      if (got.data !== exp.data)       fail_value("wb_o.data", exp.data, got.data);
   endtask

   task automatic check_busy(input logic exp, input logic got);
      if (got !== exp) fail_value("busy_o", 32'(exp), 32'(got));
   endtask

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};   // one step per bit
      end
      return v;
   endfunction

   function automatic logic [31:0] rand_pc();
      logic [31:0] v;
      v = rand_bits(30);
      return {v[29:0], 2'b00};   // word aligned
   endfunction

   function automatic instr_u mk_r(input logic [6:0] f7, input logic [2:0] f3,
                                   input logic [4:0] rd, input logic [6:0] opc);
      instr_u ins;
      ins.r_fmt = '{funct7: f7, rs2: 5'd2, rs1: 5'd1, funct3: f3, rd: rd, opcode: opc};
      return ins;
   endfunction

   function automatic instr_u mk_u(input logic [6:0] opc, input logic [19:0] imm,
                                   input logic [4:0] rd);
      instr_u ins;
      ins.u_fmt = '{imm20: imm, rd: rd, opcode: opc};
      return ins;
   endfunction

   // rv32im result from the encoding rules
   function automatic wb_t ref_wb(input instr_u ins, input logic [31:0] a, input logic [31:0] b,
                                  input logic [31:0] pc);
      wb_t                r;
      logic [63:0]        prod;
      logic signed [31:0] sa;
      logic signed [31:0] sb;
      logic               legal;
      logic               ovf;
      sa    = a;
      sb    = b;
      prod  = {32'b0, a} * {32'b0, b};
      ovf   = (a == 32'h8000_0000) && (b == 32'hffff_ffff); // most negative by minus one
      legal = 1'b1;
      r     = '{valid: 1'b1, illegal: 1'b0, rd: ins.r_fmt.rd, data: '0};
      case (ins.r_fmt.opcode)
         OPC_LUI:   r.data = {ins.u_fmt.imm20, 12'b0};
         OPC_AUIPC: r.data = pc + {ins.u_fmt.imm20, 12'b0};
         OPC_JAL:   r.data = pc + 32'd4;
         OPC_OP: begin
            if (ins.r_fmt.funct7 == F7_MULDIV) begin
               case (ins.r_fmt.funct3)
                  3'd0: r.data = prod[31:0];
                  3'd3: r.data = prod[63:32];
                  3'd4: begin
                     if (b == 0)   r.data = 32'hffff_ffff;
                     else if (ovf) r.data = a;
                     else          r.data = sa / sb;   // signed, rounds to zero
                  end
                  3'd5: r.data = (b == 0) ? 32'hffff_ffff : a / b;
                  3'd6: begin
                     if (b == 0)   r.data = a;
                     else if (ovf) r.data = 32'd0;
                     else          r.data = sa % sb;   // sign of the dividend
                  end
                  3'd7: r.data = (b == 0) ? a : a % b;
                  default: legal = 1'b0;   // mulh, mulhsu
               endcase
            end else if (ins.r_fmt.funct7 == F7_BASE) begin
               case (ins.r_fmt.funct3)
                  3'd0: r.data = a + b;
                  3'd1: r.data = a << b[4:0];
                  3'd2: r.data = {31'b0, sa < sb};
                  3'd3: r.data = {31'b0, a < b};
                  3'd4: r.data = a ^ b;
                  3'd5: r.data = a >> b[4:0];
                  3'd6: r.data = a | b;
                  default: r.data = a & b;
               endcase
            end else if (ins.r_fmt.funct7 == F7_ALT && ins.r_fmt.funct3 == 3'd0) begin
               r.data = a - b;
            end else if (ins.r_fmt.funct7 == F7_ALT && ins.r_fmt.funct3 == 3'd5) begin
               r.data = sa >>> b[4:0];
            end else begin
               legal = 1'b0;
            end
         end
         default: legal = 1'b0;
      endcase
      if (!legal) begin
         r.illegal = 1'b1;
         r.data    = '0;
      end
      return r;
   endfunction

   // starts and ends on a falling edge
   task automatic issue_op(input instr_u ins, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] pc, input bit timed, input bit expect_rec);
      issue_i = 1'b1;
      instr_i = ins;
      op1_i   = a;
      op2_i   = b;
      pc_i    = pc;
      if (expect_rec) begin
         exp_q.push_back(ref_wb(ins, a, b, pc));
         due_q.push_back(timed ? cyc_q + 2 : -1);
      end
      @(negedge s_clk_i);
      issue_i = 1'b0;
   endtask

   task automatic run_mdu(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b);
      issue_op(mk_r(F7_MULDIV, f3, 5'(rand_bits(5)), OPC_OP), a, b, rand_pc(), 0, 1);
      while (!wb_o.valid) begin
         check_busy(1'b1, busy_o);  // busy until the record shows
         @(negedge s_clk_i);
      end
      check_busy(1'b0, busy_o);
      @(negedge s_clk_i);
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < DRAIN_MAX) begin
         @(posedge s_clk_i);
         n++;
      end
      @(negedge s_clk_i);
   endtask

   task automatic hold_no_record(input int n, input string why);
      repeat (n) begin
         @(negedge s_clk_i);
         if (wb_o.valid) abort_run(why);
      end
   endtask

   always @(posedge s_clk_i) begin
      cyc_q <= cyc_q + 1;
      if (cyc_q > LIMIT) abort_run("timeout, the run took too many cycles");
   end

   // compare every record against the oldest expectation
   always @(negedge s_clk_i) begin
      wb_t exp;
      int  due;
      if (!rst_i && wb_o.valid) begin
         if (exp_q.size() == 0) abort_run("writeback record with nothing issued");
         exp = exp_q.pop_front();
         due = due_q.pop_front();
         check_wb(exp, wb_o);
         if (due >= 0 && due != cyc_q)
            abort_run($sformatf("record came in cycle %0d instead of %0d", cyc_q, due));
      end
   end

   initial begin
      logic [2:0] f3;
      s_clk_i = 1'b0;
      rst_i   = 1'b1;
      stall_i = 1'b0;
      flush_i = 1'b0;
      issue_i = 1'b0;
      instr_i = '0;
      op1_i   = '0;
      op2_i   = '0;
      pc_i    = '0;
      lfsr_q  = 32'h5dcb33d5;
      mdu_f3  = '{3'd0, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7};
      repeat (5) @(negedge s_clk_i);
      rst_i = 1'b0;
      @(negedge s_clk_i);
      check_busy(1'b0, busy_o);
      if (wb_o.valid) abort_run("writeback valid right after reset");

      // back to back register ops
      for (int i = 0; i < N_ALU; i++) begin
         f3 = 3'(rand_bits(3));
         issue_op(mk_r((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) ? F7_ALT : F7_BASE,
                       f3, 5'(rand_bits(5)), OPC_OP),
                  rand_bits(32), rand_bits(32), rand_pc(), 1, 1);
      end
      // upper immediates and link
      for (int i = 0; i < 4; i++) begin
         issue_op(mk_u(OPC_LUI, 20'(rand_bits(20)), 5'(rand_bits(5))), '0, '0, rand_pc(), 1, 1);
         issue_op(mk_u(OPC_AUIPC, 20'(rand_bits(20)), 5'(rand_bits(5))), '0, '0, rand_pc(), 1, 1);
         issue_op(mk_u(OPC_JAL, 20'(rand_bits(20)), 5'(rand_bits(5))), '0, '0, rand_pc(), 1, 1);
      end
      wait_drain();

      // multiply and divide with some zero and small divisors
      for (int i = 0; i < N_MDU; i++) begin
         f3 = mdu_f3[3'(rand_bits(3) % 6)];
         if (i % 8 == 3)      run_mdu(f3, rand_bits(32), 32'd0);
         else if (i % 8 == 5) run_mdu(f3, rand_bits(32), rand_bits(8));
         else                 run_mdu(f3, rand_bits(32), rand_bits(32));
      end
      run_mdu(3'd4, 32'h8000_0000, 32'hffff_ffff);
      run_mdu(3'd6, 32'h8000_0000, 32'hffff_ffff);
      run_mdu(3'd4, 32'hffff_fff9, 32'd2); // negative quotient rounds to zero

      // stall an alu op in decode
      issue_op(mk_r(F7_BASE, 3'd0, 5'd7, OPC_OP),
               rand_bits(32), rand_bits(32), 32'h100, 0, 1);
      stall_i = 1'b1;
      hold_no_record(4, "record produced while stalled");
      stall_i = 1'b0;
      wait_drain();

      // stall a running mdu op
      issue_op(mk_r(F7_MULDIV, 3'd5, 5'd9, OPC_OP),
               rand_bits(32), rand_bits(16), 32'h200, 0, 1);
      repeat (10) @(negedge s_clk_i);
      stall_i = 1'b1;
      hold_no_record(6, "mdu record produced while stalled");
      check_busy(1'b1, busy_o);
      stall_i = 1'b0;
      wait_drain();

      // flush an mdu op mid flight
      issue_op(mk_r(F7_MULDIV, 3'd4, 5'd3, OPC_OP), rand_bits(32), 32'd13, 32'h300, 0, 0);
      repeat (6) @(negedge s_clk_i);
      flush_i = 1'b1;
      @(negedge s_clk_i);
      flush_i = 1'b0;
      check_busy(1'b0, busy_o);
      hold_no_record(40, "flushed op still produced a record");
      issue_op(mk_r(F7_BASE, 3'd4, 5'd4, OPC_OP),
               rand_bits(32), rand_bits(32), 32'h400, 1, 1);
      wait_drain();
      run_mdu(3'd0, rand_bits(32), rand_bits(32));

      // illegal encodings
      issue_op(mk_r(F7_MULDIV, 3'd1, 5'd5, OPC_OP),
               rand_bits(32), rand_bits(32), 32'h500, 1, 1);
      issue_op(mk_r(F7_BASE, 3'd2, 5'd6, 7'b0000011),
               rand_bits(32), rand_bits(32), 32'h504, 1, 1);
      issue_op(mk_r(F7_ALT, 3'd1, 5'd8, OPC_OP),
               rand_bits(32), rand_bits(32), 32'h508, 1, 1);
      wait_drain();

      if (exp_q.size() != 0) begin
         abort_run("some expected records never arrived");
      end else begin
         $display("Test OK");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: common/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// datapath width for operands, pc and results
`define EXEC_XLEN 32

// one shift-add or restoring step per cycle
`define MDU_STEPS 32

// jal link value is pc plus this
`define LINK_INCR 4

`endif

// File: common/exec_pkg.sv
`default_nettype none

`include "exec_params.svh"

package exec_pkg;

   typedef enum logic [1:0] {
      UNIT_ALU = 2'd0,
      UNIT_MDU = 2'd1,
      UNIT_PC  = 2'd2  // auipc and jal
   } unit_e;

   typedef enum logic [4:0] {
      FN_ADD, FN_SUB, FN_SLL, FN_SLT, FN_SLTU,
      FN_XOR, FN_SRL, FN_SRA, FN_OR, FN_AND,
      FN_LUI, FN_AUIPC, FN_LINK,
      FN_MUL, FN_MULHU, FN_DIV, FN_DIVU, FN_REM, FN_REMU,
      FN_ILL // undecodable encoding
   } func_e;

   typedef struct packed {
      logic                  valid;
      unit_e                 unit;
      func_e                 func;
      logic [4:0]            rd;
      logic [19:0]           payload; // imm20 of u-type and jal
      logic [`EXEC_XLEN-1:0] op1;
      logic [`EXEC_XLEN-1:0] op2;
      logic [`EXEC_XLEN-1:0] pc;
   } dec_op_t;

   typedef struct packed {
      logic                  valid;
      logic                  illegal;
      logic [4:0]            rd;
      logic [`EXEC_XLEN-1:0] data;
   } wb_t;

endpackage

`default_nettype wire

// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

   // major opcodes handled by this stage
   localparam logic [6:0] OPC_OP    = 7'b0110011; // reg-reg alu and m-ext
   localparam logic [6:0] OPC_LUI   = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC = 7'b0010111;
   localparam logic [6:0] OPC_JAL   = 7'b1101111;

   localparam logic [6:0] F7_BASE   = 7'b0000000;
   localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra
   localparam logic [6:0] F7_MULDIV = 7'b0000001;

   // funct3 for base integer ops
   localparam logic [2:0] F3_ADD  = 3'd0; // add or sub by funct7
   localparam logic [2:0] F3_SLL  = 3'd1;
   localparam logic [2:0] F3_SLT  = 3'd2;
   localparam logic [2:0] F3_SLTU = 3'd3;
   localparam logic [2:0] F3_XOR  = 3'd4;
   localparam logic [2:0] F3_SR   = 3'd5; // srl or sra by funct7
   localparam logic [2:0] F3_OR   = 3'd6;
   localparam logic [2:0] F3_AND  = 3'd7;

   // funct3 for the m extension, mulh and mulhsu not supported
   localparam logic [2:0] F3_MUL   = 3'd0;
   localparam logic [2:0] F3_MULHU = 3'd3;
   localparam logic [2:0] F3_DIV   = 3'd4;
   localparam logic [2:0] F3_DIVU  = 3'd5;
   localparam logic [2:0] F3_REM   = 3'd6;
   localparam logic [2:0] F3_REMU  = 3'd7;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [19:0] imm20; // upper immediate, also raw j-imm bits
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   // same 32 bits seen as r-type or u-type
   typedef union packed {
      r_fmt_t r_fmt;
      u_fmt_t u_fmt;
   } instr_u;

endpackage

`default_nettype wire

// File: design/decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module decoder import isa_pkg::*, exec_pkg::*; (
   input  logic                  s_clk_i,
   input  logic                  rst_i,
   input  logic                  stall_i,
   input  logic                  flush_i,
   input  logic                  issue_i,
   input  instr_u                instr_i,
   input  logic [`EXEC_XLEN-1:0] op1_i,
   input  logic [`EXEC_XLEN-1:0] op2_i,
   input  logic [`EXEC_XLEN-1:0] pc_i,
   output dec_op_t               dec_o
);
   unit_e       unit;
   func_e       func;
   logic [4:0]  rd;
   logic [19:0] payload;

   always_comb begin
      unit    = UNIT_ALU;
      func    = FN_ILL;             // anything unmatched stays illegal
      payload = '0;
      rd      = instr_i.r_fmt.rd;
      case (instr_i.r_fmt.opcode)
         OPC_OP: begin
            case (instr_i.r_fmt.funct7)
               F7_BASE: begin
                  case (instr_i.r_fmt.funct3)
                     F3_ADD:  func = FN_ADD;
                     F3_SLL:  func = FN_SLL;
                     F3_SLT:  func = FN_SLT;
                     F3_SLTU: func = FN_SLTU;
                     F3_XOR:  func = FN_XOR;
                     F3_SR:   func = FN_SRL;
                     F3_OR:   func = FN_OR;
                     F3_AND:  func = FN_AND;
                     default: func = FN_ILL;
                  endcase
               end
               F7_ALT: begin
                  if (instr_i.r_fmt.funct3 == F3_ADD) func = FN_SUB;
                  if (instr_i.r_fmt.funct3 == F3_SR)  func = FN_SRA;
               end
               F7_MULDIV: begin
                  unit = UNIT_MDU;
                  case (instr_i.r_fmt.funct3)
                     F3_MUL:   func = FN_MUL;
                     F3_MULHU: func = FN_MULHU;
                     F3_DIV:   func = FN_DIV;
                     F3_DIVU:  func = FN_DIVU;
                     F3_REM:   func = FN_REM;
                     F3_REMU:  func = FN_REMU;
                     default:  unit = UNIT_ALU; // mulh, mulhsu
                  endcase
               end
               default: func = FN_ILL;
            endcase
         end
         OPC_LUI: begin
            func    = FN_LUI;
            payload = instr_i.u_fmt.imm20;
            rd      = instr_i.u_fmt.rd;
         end
         OPC_AUIPC: begin
            unit    = UNIT_PC;
            func    = FN_AUIPC;
            payload = instr_i.u_fmt.imm20;
            rd      = instr_i.u_fmt.rd;
         end
         OPC_JAL: begin
            unit    = UNIT_PC;
            func    = FN_LINK;             // only the link value, no redirect
            payload = instr_i.u_fmt.imm20;
            rd      = instr_i.u_fmt.rd;
         end
         default: func = FN_ILL;
      endcase
   end

   always_ff @(posedge s_clk_i) begin
      if (rst_i || flush_i) begin
         dec_o.valid <= 1'b0;
      end else if (!stall_i) begin
         dec_o.valid <= issue_i;          // one cycle per issue
      end
      if (!stall_i && issue_i) begin     // fields held until next issue
         dec_o.unit    <= unit;
         dec_o.func    <= func;
         dec_o.rd      <= rd;
         dec_o.payload <= payload;
         dec_o.op1     <= op1_i;
         dec_o.op2     <= op2_i;
         dec_o.pc      <= pc_i;
      end
   end

endmodule

`default_nettype wire

// File: design/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module exec_unit import isa_pkg::*, exec_pkg::*; (
   input  logic                  s_clk_i,
   input  logic                  rst_i,
   input  logic                  stall_i,
   input  logic                  flush_i,
   input  logic                  issue_i,
   input  instr_u                instr_i,
   input  logic [`EXEC_XLEN-1:0] op1_i,
   input  logic [`EXEC_XLEN-1:0] op2_i,
   input  logic [`EXEC_XLEN-1:0] pc_i,
   output wb_t                   wb_o,
   output logic                  busy_o
);
   dec_op_t               dec_op;
   logic [`EXEC_XLEN-1:0] ex_result;
   logic                  ex_finished, ex_illegal;

   decoder u_dec (
      .s_clk_i (s_clk_i),
      .rst_i   (rst_i),
      .stall_i (stall_i),
      .flush_i (flush_i),
      .issue_i (issue_i),
      .instr_i (instr_i),
      .op1_i   (op1_i),
      .op2_i   (op2_i),
      .pc_i    (pc_i),
      .dec_o   (dec_op)
   );

   executor u_exe (
      .s_clk_i    (s_clk_i),
      .rst_i      (rst_i),
      .stall_i    (stall_i),
      .flush_i    (flush_i),
      .dec_i      (dec_op),
      .finished_o (ex_finished),
      .result_o   (ex_result),
      .illegal_o  (ex_illegal)
   );

   writeback u_wb (
      .s_clk_i    (s_clk_i),
      .rst_i      (rst_i),
      .stall_i    (stall_i),
      .flush_i    (flush_i),
      .dec_i      (dec_op),
      .finished_i (ex_finished),
      .illegal_i  (ex_illegal),
      .result_i   (ex_result),
      .wb_o       (wb_o),
      .busy_o     (busy_o)
   );

endmodule

`default_nettype wire

// File: design/writeback.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module writeback import exec_pkg::*; (
   input  logic                  s_clk_i,
   input  logic                  rst_i,
   input  logic                  stall_i,
   input  logic                  flush_i,
   input  dec_op_t               dec_i,
   input  logic                  finished_i,
   input  logic                  illegal_i,
   input  logic [`EXEC_XLEN-1:0] result_i,
   output wb_t                   wb_o,
   output logic                  busy_o
);
   logic mdu_pend_q;   // mdu op left decode, record not out yet
   logic mdu_in_dec;

   assign mdu_in_dec = dec_i.valid && (dec_i.unit == UNIT_MDU);
   assign busy_o     = mdu_pend_q || mdu_in_dec;

   always_ff @(posedge s_clk_i) begin
      if (rst_i || flush_i) begin
         wb_o.valid <= 1'b0;
         mdu_pend_q <= 1'b0;
      end else begin
         wb_o.valid <= finished_i && !stall_i;   // single-cycle record
         if (!stall_i) begin
            if (finished_i)      mdu_pend_q <= 1'b0; // also covers div by zero
            else if (mdu_in_dec) mdu_pend_q <= 1'b1;
         end
      end
      if (finished_i && !stall_i) begin
         wb_o.illegal <= illegal_i;
         wb_o.rd      <= dec_i.rd;
         wb_o.data    <= illegal_i ? '0 : result_i;
      end
   end

endmodule

`default_nettype wire

// File: exec_unit.f
+incdir+common
common/isa_pkg.sv
common/exec_pkg.sv
design/decoder.sv
executor/alu.sv
executor/muldiv.sv
executor/executor.sv
design/writeback.sv
design/exec_unit.sv
bench/exec_unit_props.sv
bench/exec_unit_tb.sv

// File: executor/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module alu import exec_pkg::*; (
   input  func_e                 func_i,
   input  logic [`EXEC_XLEN-1:0] op1_i,
   input  logic [`EXEC_XLEN-1:0] op2_i,
   input  logic [`EXEC_XLEN-1:0] pc_i,
   input  logic [`EXEC_XLEN-1:0] pc_offset_i,
   output logic [`EXEC_XLEN-1:0] result_o
);
   logic [4:0] shamt;

   assign shamt = op2_i[4:0]; // rv32 uses low five bits

   always_comb begin
      case (func_i)
         FN_ADD:   result_o = op1_i + op2_i;
         FN_SUB:   result_o = op1_i - op2_i;
         FN_SLL:   result_o = op1_i << shamt;
         FN_SLT:   result_o = {{(`EXEC_XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
         FN_SLTU:  result_o = {{(`EXEC_XLEN-1){1'b0}}, op1_i < op2_i};
         FN_XOR:   result_o = op1_i ^ op2_i;
         FN_SRL:   result_o = op1_i >> shamt;
         FN_SRA:   result_o = $unsigned($signed(op1_i) >>> shamt); // sign fill
         FN_OR:    result_o = op1_i | op2_i;
         FN_AND:   result_o = op1_i & op2_i;
         FN_LUI:   result_o = pc_offset_i;               // imm already at bit 12
         FN_AUIPC: result_o = pc_i + pc_offset_i;
         FN_LINK:  result_o = pc_i + `EXEC_XLEN'(`LINK_INCR); // return address
         default:  result_o = '0;                        // illegal or mdu op
      endcase
   end

endmodule

`default_nettype wire

// File: executor/executor.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module executor import exec_pkg::*; (
   input  logic                  s_clk_i,
   input  logic                  rst_i,
   input  logic                  stall_i,
   input  logic                  flush_i,
   input  dec_op_t               dec_i,
   output logic                  finished_o,
   output logic [`EXEC_XLEN-1:0] result_o,
   output logic                  illegal_o
);
   logic [`EXEC_XLEN-1:0] alu_result, mdu_result, pc_offset;
   logic                  mdu_finished, is_mdu;

   assign is_mdu = dec_i.unit == UNIT_MDU;

   // u-type immediate lands on bits 31:12
   assign pc_offset = (dec_i.func inside {FN_LUI, FN_AUIPC}) ? {dec_i.payload, 12'b0} : '0;

   assign result_o   = is_mdu ? mdu_result : alu_result;
   assign finished_o = is_mdu ? mdu_finished : dec_i.valid; // alu done in one pass
   assign illegal_o  = dec_i.func == FN_ILL;

   alu u_alu (
      .func_i      (dec_i.func),
      .op1_i       (dec_i.op1),
      .op2_i       (dec_i.op2),
      .pc_i        (dec_i.pc),
      .pc_offset_i (pc_offset),
      .result_o    (alu_result)
   );

   muldiv u_mdu (
      .s_clk_i    (s_clk_i),
      .rst_i      (rst_i),
      .stall_i    (stall_i),
      .flush_i    (flush_i),
      .start_i    (dec_i.valid && is_mdu), // taken only when idle
      .func_i     (dec_i.func),
      .op1_i      (dec_i.op1),
      .op2_i      (dec_i.op2),
      .finished_o (mdu_finished),
      .result_o   (mdu_result)
   );

endmodule

`default_nettype wire

// File: executor/muldiv.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module muldiv import exec_pkg::*; (
   input  logic                  s_clk_i,
   input  logic                  rst_i,
   input  logic                  stall_i,
   input  logic                  flush_i,
   input  logic                  start_i,
   input  func_e                 func_i,
   input  logic [`EXEC_XLEN-1:0] op1_i,
   input  logic [`EXEC_XLEN-1:0] op2_i,
   output logic                  finished_o,
   output logic [`EXEC_XLEN-1:0] result_o
);
   localparam int XL    = `EXEC_XLEN;
   localparam int CNT_W = $clog2(`MDU_STEPS + 1);

   logic             active_q;
   logic [CNT_W-1:0] cnt_q;        // steps done so far
   logic [2*XL-1:0]  acc_q;        // mul product, or rem:quo for div
   logic [XL-1:0]    bmag_q;
   func_e            func_q;
   logic             neg_q;        // negate final quotient or remainder
   logic             is_div, is_div_q, is_signed, div_zero, div0_fin, go, done;
   logic [XL-1:0]    amag, bmag, quo, rem;

   // one iteration, restoring divide or shift-add multiply
   function automatic logic [2*XL-1:0] step(input logic [2*XL-1:0] acc,
                                            input logic [XL-1:0] b,
                                            input logic div);
      logic [XL:0] diff;
      logic [XL:0] sum;
      diff = acc[2*XL-1:XL-1] - {1'b0, b};            // shifted rem minus divisor
      sum  = {1'b0, acc[2*XL-1:XL]} + (acc[0] ? {1'b0, b} : '0);
      if (div) begin
         if (!diff[XL]) return {diff[XL-1:0], acc[XL-2:0], 1'b1}; // fits, quotient bit 1
         else           return {acc[2*XL-2:0], 1'b0};            // restore
      end else begin
         return {sum, acc[XL-1:1]};                    // add then shift right
      end
   endfunction

   assign is_div    = func_i inside {FN_DIV, FN_DIVU, FN_REM, FN_REMU};
   assign is_div_q  = func_q inside {FN_DIV, FN_DIVU, FN_REM, FN_REMU};
   assign is_signed = func_i inside {FN_DIV, FN_REM};
   assign div_zero  = is_div && (op2_i == '0);
   assign amag      = (is_signed && op1_i[XL-1]) ? -op1_i : op1_i;
   assign bmag      = (is_signed && op2_i[XL-1]) ? -op2_i : op2_i;

   assign div0_fin   = start_i && !active_q && div_zero; // no iterations needed
   assign go         = start_i && !active_q && !stall_i && !div_zero;
   assign done       = active_q && (cnt_q == CNT_W'(`MDU_STEPS));
   assign finished_o = done || div0_fin;

   always_ff @(posedge s_clk_i) begin
      if (rst_i || flush_i) begin       // flush aborts any running op
         active_q <= 1'b0;
         cnt_q    <= '0;
      end else if (!stall_i) begin
         if (go) begin
            active_q <= 1'b1;
            cnt_q    <= CNT_W'(1);       // first step taken at start
         end else if (done) begin
            active_q <= 1'b0;
         end else if (active_q) begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   always_ff @(posedge s_clk_i) begin
      if (!stall_i) begin
         if (go) begin
            acc_q  <= step({{XL{1'b0}}, amag}, bmag, is_div);
            bmag_q <= bmag;
            func_q <= func_i;
            neg_q  <= (func_i == FN_DIV) ? (op1_i[XL-1] ^ op2_i[XL-1]) :
                      (func_i == FN_REM) ? op1_i[XL-1] : 1'b0; // rem follows dividend
         end else if (active_q && !done) begin
            acc_q <= step(acc_q, bmag_q, is_div_q);
         end
      end
   end

   // min / -1 gives magnitude 2^31 which negates back to min, rem 0
   assign quo = neg_q ? -acc_q[XL-1:0] : acc_q[XL-1:0];
   assign rem = neg_q ? -acc_q[2*XL-1:XL] : acc_q[2*XL-1:XL];

   always_comb begin
      if (div0_fin) begin
         result_o = (func_i inside {FN_DIV, FN_DIVU}) ? '1 : op1_i; // rv32m div by zero
      end else begin
         case (func_q)
            FN_MUL:         result_o = acc_q[XL-1:0];
            FN_MULHU:       result_o = acc_q[2*XL-1:XL];
            FN_DIV, FN_DIVU: result_o = quo;
            default:        result_o = rem;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f exec_unit.f --top-module exec_unit_tb -o exec_unit_sim \
   && ./obj_dir/exec_unit_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
